// ==== mem_subsystem.f ====
verilog/mem_pkg.sv
verilog/line_if.sv
verilog/line_arbiter.sv
verilog/cacheline_adapter.sv
verilog/mem_subsystem.sv
verif/burst_mem_model.sv
verif/mem_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
        -f mem_subsystem.f \
        --top-module mem_subsystem_tb \
        -Mdir obj_dir; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/Vmem_subsystem_tb 2>&1)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi

echo "Pass message not found in the simulation output."
exit 1

// ==== verif/burst_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

// Burst memory for the testbench. Once a request shows up it waits a fixed
// number of cycles, then answers every beat of the line on consecutive cycles.
module burst_mem_model #(
    parameter int BEAT_BITS   = 64,
    parameter int DEPTH_WORDS = 256,
    parameter int WAIT_CYCLES = 2,
    parameter int BURST_BEATS = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  mem_pkg::addr_t        mem_address,
    input  logic [BEAT_BITS-1:0]  mem_wdata,
    output logic [BEAT_BITS-1:0]  mem_rdata,
    output logic                  mem_resp
);

    localparam int BYTE_SHIFT = $clog2(BEAT_BITS / 8);
    localparam int INDEX_W    = $clog2(DEPTH_WORDS);
    localparam int LAST_STEP  = WAIT_CYCLES + BURST_BEATS - 1;

    logic [BEAT_BITS-1:0]  store [DEPTH_WORDS];
    logic                  busy;
    int                    step;
    logic [INDEX_W-1:0]    index;

    // The cycle in which the request first appears counts as the first wait cycle.
    assign mem_resp  = busy && (step >= WAIT_CYCLES);
    assign index     = mem_address[BYTE_SHIFT +: INDEX_W] + INDEX_W'(step - WAIT_CYCLES);
    assign mem_rdata = store[index];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            step <= 0;
            // Each beat starts out holding its own byte address in both halves.
            for (int i = 0; i < DEPTH_WORDS; i++) begin
                store[i] <= {(BEAT_BITS / 32){32'(i << BYTE_SHIFT)}};
            end
        end else begin
            if (!busy && (mem_read || mem_write)) begin
                busy <= 1'b1;
                step <= 1;
            end else if (busy) begin
                if (step == LAST_STEP) begin
                    busy <= 1'b0;
                end
                step <= step + 1;
            end
            if (mem_resp && mem_write) begin
                store[index] <= mem_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/mem_subsystem_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_tb;

    localparam int LINE_BITS           = mem_pkg::LINE_BITS_DEFAULT;
    localparam int BEAT_BITS           = mem_pkg::BEAT_BITS_DEFAULT;
    localparam int LINE_BYTES          = LINE_BITS / 8;
    localparam int OFFSET_BITS         = $clog2(LINE_BYTES);
    localparam int NUM_LINES           = 64;
    localparam int N_TRANSFERS         = 28;
    localparam int CYCLES_PER_TRANSFER = 40;

    typedef logic [LINE_BITS-1:0] line_t;

    logic                  clk;
    logic                  rst;
    logic                  icache_read;
    mem_pkg::addr_t        icache_address;
    line_t                 icache_rdata;
    logic                  icache_resp;
    logic                  dcache_read;
    logic                  dcache_write;
    mem_pkg::addr_t        dcache_address;
    line_t                 dcache_wdata;
    line_t                 dcache_rdata;
    logic                  dcache_resp;
    logic                  mem_read;
    logic                  mem_write;
    mem_pkg::addr_t        mem_address;
    logic [BEAT_BITS-1:0]  mem_wdata;
    logic [BEAT_BITS-1:0]  mem_rdata;
    logic                  mem_resp;

    line_t                 shadow [NUM_LINES];
    logic [31:0]           lfsr;

    mem_subsystem #(
        .LINE_BITS (LINE_BITS),
        .BEAT_BITS (BEAT_BITS)
    ) uut (
        .clk            (clk),
        .rst            (rst),
        .icache_read    (icache_read),
        .icache_address (icache_address),
        .icache_rdata   (icache_rdata),
        .icache_resp    (icache_resp),
        .dcache_read    (dcache_read),
        .dcache_write   (dcache_write),
        .dcache_address (dcache_address),
        .dcache_wdata   (dcache_wdata),
        .dcache_rdata   (dcache_rdata),
        .dcache_resp    (dcache_resp),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_address    (mem_address),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_resp       (mem_resp)
    );

    burst_mem_model #(
        .BEAT_BITS   (BEAT_BITS),
        .DEPTH_WORDS (NUM_LINES * LINE_BITS / BEAT_BITS)
    ) mem_model (
        .clk         (clk),
        .rst         (rst),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (N_TRANSFERS * CYCLES_PER_TRANSFER + 20) @(posedge clk);
        stop_run("Watchdog expired before all tests finished.");
    end

    // *************************************************************************
    // Reference model and stimulus helpers
    // *************************************************************************

    function automatic mem_pkg::addr_t align_line(input mem_pkg::addr_t addr);
        return addr & ~mem_pkg::addr_t'(LINE_BYTES - 1);
    endfunction

    function automatic int line_index(input mem_pkg::addr_t addr);
        return int'(addr >> OFFSET_BITS);
    endfunction

    // Memory starts with every 64-bit beat holding its byte address twice.
    function automatic line_t pattern_line(input mem_pkg::addr_t line_addr);
        line_t          line;
        mem_pkg::addr_t beat_addr;
        for (int b = 0; b < LINE_BITS / BEAT_BITS; b++) begin
            beat_addr = line_addr + mem_pkg::addr_t'(b * BEAT_BITS / 8);
            line[b*BEAT_BITS +: BEAT_BITS] = {beat_addr, beat_addr};
        end
        return line;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic line_t random_line();
        line_t line;
        for (int k = 0; k < LINE_BITS / 32; k++) begin
            line[k*32 +: 32] = draw_bits(32);
        end
        return line;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_addr(input string name, input mem_pkg::addr_t got,
                                input mem_pkg::addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic compare_grant(input string name, input mem_pkg::grant_e got,
                                 input mem_pkg::grant_e exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH at %0t: %s got %s expected %s",
                               $time, name, got.name(), exp.name()));
        end
    endtask

    // Waits for the port's resp, watching the burst address, then drops the request.
    task automatic wait_for_resp(input logic on_dcache, input mem_pkg::addr_t line_addr,
                                 output line_t line);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2 * CYCLES_PER_TRANSFER) begin
                stop_run("No response arrived from the memory subsystem in time.");
            end
            if (mem_read || mem_write) begin
                compare_addr("mem_address", mem_address, line_addr);
            end
            compare_bit(on_dcache ? "icache_resp" : "dcache_resp",
                        on_dcache ? icache_resp : dcache_resp, 1'b0);
            seen = on_dcache ? dcache_resp : icache_resp;
            line = on_dcache ? dcache_rdata : icache_rdata;
        end
        @(posedge clk);
        icache_read  <= 1'b0;
        dcache_read  <= 1'b0;
        dcache_write <= 1'b0;
    endtask

    task automatic icache_fetch(input mem_pkg::addr_t addr, output line_t line);
        @(posedge clk);
        icache_read    <= 1'b1;
        icache_address <= addr;
        wait_for_resp(1'b0, align_line(addr), line);
    endtask

    task automatic dcache_load(input mem_pkg::addr_t addr, output line_t line);
        @(posedge clk);
        dcache_read    <= 1'b1;
        dcache_address <= addr;
        wait_for_resp(1'b1, align_line(addr), line);
    endtask

    task automatic store_line(input mem_pkg::addr_t addr, input line_t data);
        line_t ignored;
        @(posedge clk);
        dcache_write   <= 1'b1;
        dcache_address <= addr;
        dcache_wdata   <= data;
        wait_for_resp(1'b1, align_line(addr), ignored);
        shadow[line_index(addr)] = data;
    endtask

    // *************************************************************************
    // Directed tests
    // *************************************************************************

    task automatic test_reset_idle();
        repeat (3) begin
            @(negedge clk);
            compare_bit("mem_read", mem_read, 1'b0);
            compare_bit("mem_write", mem_write, 1'b0);
            compare_bit("icache_resp", icache_resp, 1'b0);
            compare_bit("dcache_resp", dcache_resp, 1'b0);
        end
    endtask

    task automatic test_icache_read();
        line_t got;
        icache_fetch(32'h0000_0060, got);
        compare_line("icache_rdata", got, pattern_line(32'h0000_0060));
    endtask

    task automatic test_write_then_read();
        line_t data;
        line_t got;
        data = random_line();
        store_line(32'h0000_0140, data);
        dcache_load(32'h0000_0140, got);
        compare_line("dcache_rdata", got, data);
        dcache_load(32'h0000_0160, got);
        compare_line("dcache_rdata", got, pattern_line(32'h0000_0160));
    endtask

    task automatic test_same_cycle();
        line_t           i_line;
        line_t           d_line;
        int              cycle;
        int              i_at;
        int              d_at;
        mem_pkg::grant_e first;
        cycle = 0;
        i_at  = 0;
        d_at  = 0;
        @(posedge clk);
        icache_read    <= 1'b1;
        icache_address <= 32'h0000_0200;
        dcache_read    <= 1'b1;
        dcache_address <= 32'h0000_0220;
        while (i_at == 0 || d_at == 0) begin
            @(negedge clk);
            cycle++;
            if (cycle > 2 * CYCLES_PER_TRANSFER) begin
                stop_run("Requests raised in the same cycle did not both complete.");
            end
            if (icache_resp && i_at == 0) begin
                i_at   = cycle;
                i_line = icache_rdata;
            end
            if (dcache_resp && d_at == 0) begin
                d_at   = cycle;
                d_line = dcache_rdata;
            end
            @(posedge clk);
            if (i_at != 0) icache_read <= 1'b0;
            if (d_at != 0) dcache_read <= 1'b0;
        end
        if (i_at < d_at) begin
            first = mem_pkg::GRANT_ICACHE;
        end else if (d_at < i_at) begin
            first = mem_pkg::GRANT_DCACHE;
        end else begin
            first = mem_pkg::GRANT_NONE;
        end
        compare_grant("first port served", first, mem_pkg::GRANT_ICACHE);
        compare_line("icache_rdata", i_line, shadow[line_index(32'h0000_0200)]);
        compare_line("dcache_rdata", d_line, shadow[line_index(32'h0000_0220)]);
    endtask

    task automatic test_unaligned_read();
        line_t got;
        icache_fetch(32'h0000_02b4, got);
        compare_line("icache_rdata", got, pattern_line(32'h0000_02a0));
        dcache_load(32'h0000_02a0, got);
        compare_line("dcache_rdata", got, pattern_line(32'h0000_02a0));
    endtask

    // Traffic stays within eight lines so that reads often hit earlier writes.
    task automatic test_random_traffic();
        logic [31:0]    line_sel;
        logic [31:0]    offset;
        logic [1:0]     op;
        mem_pkg::addr_t addr;
        line_t          got;
        for (int n = 0; n < 20; n++) begin
            line_sel = draw_bits(3);
            offset   = draw_bits(OFFSET_BITS);
            op       = 2'(draw_bits(2));
            addr     = (line_sel << OFFSET_BITS) | offset;
            case (op)
                2'd0: begin
                    icache_fetch(addr, got);
                    compare_line("icache_rdata", got, shadow[line_index(addr)]);
                end
                2'd1: begin
                    dcache_load(addr, got);
                    compare_line("dcache_rdata", got, shadow[line_index(addr)]);
                end
                default: begin
                    store_line(addr, random_line());
                end
            endcase
        end
    endtask

    initial begin
        rst            = 1'b1;
        icache_read    = 1'b0;
        icache_address = '0;
        dcache_read    = 1'b0;
        dcache_write   = 1'b0;
        dcache_address = '0;
        dcache_wdata   = '0;
        lfsr           = 32'hb4ad_f1de;
        for (int i = 0; i < NUM_LINES; i++) begin
            shadow[i] = pattern_line(mem_pkg::addr_t'(i * LINE_BYTES));
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        test_reset_idle();
        test_icache_read();
        test_write_then_read();
        test_same_cycle();
        test_unaligned_read();
        test_random_traffic();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cacheline_adapter.sv ====
`timescale 1ns/10ps
`default_nettype none

// Turns one line read or write into a burst of beats on the memory bus.
// Beats go lowest first; one shift register serves both directions.
module cacheline_adapter #(
    parameter int LINE_BITS = 256,
    parameter int BEAT_BITS = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    line_if.responder             line,
    output logic                  mem_read,
    output logic                  mem_write,
    output mem_pkg::addr_t        mem_address,
    output logic [BEAT_BITS-1:0]  mem_wdata,
    input  logic [BEAT_BITS-1:0]  mem_rdata,
    input  logic                  mem_resp
);

    localparam int BEATS      = LINE_BITS / BEAT_BITS;
    localparam int CNT_W      = (BEATS > 1) ? $clog2(BEATS) : 1;
    localparam int OFFSET_W   = $clog2(LINE_BITS / 8);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BURST,
        ST_DONE
    } state_e;

    state_e                state;
    logic [CNT_W-1:0]      beat_cnt;
    logic                  last_beat;
    logic                  op_write;
    mem_pkg::addr_t        addr_q;
    logic [LINE_BITS-1:0]  line_q;

    assign last_beat = (beat_cnt == CNT_W'(BEATS - 1));

    // *************************************************************************
    // Control
    // *************************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    beat_cnt <= '0;
                    if (line.read || line.write) begin
                        state <= ST_BURST;
                    end
                end
                ST_BURST: begin
                    if (mem_resp) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    // The requester drops its request in the next cycle.
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // *************************************************************************
    // Datapath
    // *************************************************************************

    // Reads shift each beat in at the top, so the first beat ends up lowest.
    // Writes shift the next beat down into the bottom slot.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && (line.read || line.write)) begin
            op_write <= line.write;
            addr_q   <= {line.address[31:OFFSET_W], {OFFSET_W{1'b0}}};
            line_q   <= line.wdata;
        end else if (state == ST_BURST && mem_resp) begin
            line_q   <= {mem_rdata, line_q[LINE_BITS-1:BEAT_BITS]};
        end
    end

    assign mem_read    = (state == ST_BURST) && !op_write;
    assign mem_write   = (state == ST_BURST) && op_write;
    assign mem_address = addr_q;
    assign mem_wdata   = line_q[BEAT_BITS-1:0];

    assign line.rdata  = line_q;
    assign line.resp   = (state == ST_DONE);

    // A line request is a read or a write and never both.
    a_rw_excl: assert property (@(posedge clk) disable iff (rst)
        !(line.read && line.write));

    // The requester holds its request and its address for the whole burst.
    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (state == ST_BURST) |-> ((line.read || line.write) && $stable(line.address)));

endmodule

`default_nettype wire

// ==== verilog/line_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

// Grants the single line path to the instruction port or the data port.
// The instruction port wins when both ask in the same idle cycle.
module line_arbiter #(
    parameter int LINE_BITS = 256
) (
    input  logic        clk,
    input  logic        rst,
    line_if.responder   icache,
    line_if.responder   dcache,
    line_if.requester   mem
);

    mem_pkg::grant_e state;
    mem_pkg::grant_e next_state;

    // *************************************************************************
    // Request and response routing
    // *************************************************************************

    always_comb begin
        mem.read     = 1'b0;
        mem.write    = 1'b0;
        mem.address  = '0;
        mem.wdata    = {LINE_BITS{1'b0}};

        icache.resp  = 1'b0;
        icache.rdata = {LINE_BITS{1'b0}};
        dcache.resp  = 1'b0;
        dcache.rdata = {LINE_BITS{1'b0}};

        case (state)
            mem_pkg::GRANT_ICACHE: begin
                mem.read     = icache.read;
                mem.write    = icache.write;
                mem.address  = icache.address;
                mem.wdata    = icache.wdata;
                icache.resp  = mem.resp;
                icache.rdata = mem.rdata;
            end
            mem_pkg::GRANT_DCACHE: begin
                mem.read     = dcache.read;
                mem.write    = dcache.write;
                mem.address  = dcache.address;
                mem.wdata    = dcache.wdata;
                dcache.resp  = mem.resp;
                dcache.rdata = mem.rdata;
            end
            default: begin
                // Idle, nothing reaches the adapter.
            end
        endcase
    end

    // *************************************************************************
    // Grant state machine
    // *************************************************************************

    always_comb begin
        next_state = state;
        case (state)
            mem_pkg::GRANT_NONE: begin
                if (icache.read || icache.write) begin
                    next_state = mem_pkg::GRANT_ICACHE;
                end else if (dcache.read || dcache.write) begin
                    next_state = mem_pkg::GRANT_DCACHE;
                end
            end
            mem_pkg::GRANT_ICACHE,
            mem_pkg::GRANT_DCACHE: begin
                // Hold the grant until the line completes.
                if (mem.resp) begin
                    next_state = mem_pkg::GRANT_NONE;
                end
            end
            default: begin
                next_state = mem_pkg::GRANT_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_pkg::GRANT_NONE;
        end else begin
            state <= next_state;
        end
    end

    // A granted port keeps its request up until its line completes.
    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        (state != mem_pkg::GRANT_NONE) |-> (mem.read || mem.write));

endmodule

`default_nettype wire

// ==== verilog/line_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// One whole-line transfer between a cache side and the memory side.
// The requester holds read or write with a stable address and wdata until
// resp is high for one cycle, and rdata is valid in that cycle.
interface line_if #(
    parameter int LINE_BITS = 256
);

    logic                  read;
    logic                  write;
    mem_pkg::addr_t        address;
    logic [LINE_BITS-1:0]  wdata;
    logic [LINE_BITS-1:0]  rdata;
    logic                  resp;

    modport requester (
        output read, write, address, wdata,
        input  rdata, resp
    );

    modport responder (
        input  read, write, address, wdata,
        output rdata, resp
    );

endinterface

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // *************************************************************************
    // Address and width defaults
    // *************************************************************************

    // Byte address used by every port in the memory subsystem.
    typedef logic [31:0] addr_t;

    // One cache line as requested by the instruction and data caches.
    localparam int LINE_BITS_DEFAULT = 256;

    // One beat on the external memory bus.
    localparam int BEAT_BITS_DEFAULT = 64;

    // *************************************************************************
    // Arbiter grant encoding
    // *************************************************************************

    // The arbiter state doubles as the grant.
    // GRANT_NONE means the arbiter is idle and the adapter sees no request.
    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_ICACHE,
        GRANT_DCACHE
    } grant_e;

endpackage

`default_nettype wire

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

// Memory side of the cached processor. Two line ports share one burst
// adapter through the arbiter.
module mem_subsystem #(
    parameter int LINE_BITS = mem_pkg::LINE_BITS_DEFAULT,
    parameter int BEAT_BITS = mem_pkg::BEAT_BITS_DEFAULT
) (
    input  logic                  clk,
    input  logic                  rst,

    // Instruction cache.
    input  logic                  icache_read,
    input  mem_pkg::addr_t        icache_address,
    output logic [LINE_BITS-1:0]  icache_rdata,
    output logic                  icache_resp,

    // Data cache.
    input  logic                  dcache_read,
    input  logic                  dcache_write,
    input  mem_pkg::addr_t        dcache_address,
    input  logic [LINE_BITS-1:0]  dcache_wdata,
    output logic [LINE_BITS-1:0]  dcache_rdata,
    output logic                  dcache_resp,

    // External memory bus.
    output logic                  mem_read,
    output logic                  mem_write,
    output mem_pkg::addr_t        mem_address,
    output logic [BEAT_BITS-1:0]  mem_wdata,
    input  logic [BEAT_BITS-1:0]  mem_rdata,
    input  logic                  mem_resp
);

    line_if #(.LINE_BITS(LINE_BITS)) icache_bus ();
    line_if #(.LINE_BITS(LINE_BITS)) dcache_bus ();
    line_if #(.LINE_BITS(LINE_BITS)) adapter_bus ();

    // The instruction port only ever reads.
    assign icache_bus.read    = icache_read;
    assign icache_bus.write   = 1'b0;
    assign icache_bus.address = icache_address;
    assign icache_bus.wdata   = '0;
    assign icache_rdata       = icache_bus.rdata;
    assign icache_resp        = icache_bus.resp;

    assign dcache_bus.read    = dcache_read;
    assign dcache_bus.write   = dcache_write;
    assign dcache_bus.address = dcache_address;
    assign dcache_bus.wdata   = dcache_wdata;
    assign dcache_rdata       = dcache_bus.rdata;
    assign dcache_resp        = dcache_bus.resp;

    line_arbiter #(
        .LINE_BITS (LINE_BITS)
    ) u_arbiter (
        .clk    (clk),
        .rst    (rst),
        .icache (icache_bus.responder),
        .dcache (dcache_bus.responder),
        .mem    (adapter_bus.requester)
    );

    cacheline_adapter #(
        .LINE_BITS (LINE_BITS),
        .BEAT_BITS (BEAT_BITS)
    ) u_adapter (
        .clk         (clk),
        .rst         (rst),
        .line        (adapter_bus.responder),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_resp    (mem_resp)
    );

endmodule

`default_nettype wire
